// File: Makefile
VERILATOR ?= verilator
TOP       ?= sru_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -Fxq "Finished with no errors"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/sru_ctrl_tb.sv
module sru_ctrl_tb
    import sru_map_pkg::*, axil_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD  = 20;
    localparam word_t SN_VALUE    = 32'h5A17_0042;
    localparam int    PULSE_SLOTS = 9;
    // cycle budget of each test, the watchdog fires after their sum plus a margin
    localparam int RUN_CYCLES = 60 + 100 + 150 + 250 + 150 + 150 + 200 + 200;

    logic               dcsclk = 1'b0;
    logic               reset;
    logic [AXIL_AW-1:0] s_awaddr_i, s_araddr_i;
    logic               s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
    logic               s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
    word_t              s_wdata_i, s_rdata_o, sru_sn_i, sru_status_i;
    resp_t              s_bresp_o, s_rresp_o;
    mask40_t            dtc_err_flag_i, dtc_sync_err_i, rdo_mask_o;
    word_t              srucfg_o, trigl1tw_o, trigl2tw_o;
    logic [PTRIG_W-1:0] ptrigcfg_o;
    logic               fee_err_or_o, dtc_link_or_o, soft_rst_o, busy_clr_o, strig_o;
    logic               trigcnt_clr_o, trigerr_clr_o, walign_o, errtest_o, ddlinit_o;
    logic               fast_cmd_o;
    logic [7:0]         fast_cmd_code_o;
    word_t              lcg_state = 32'h3d6a_1e13;
    // high-cycle counters for walign, ddlinit, strig, fast command, errtest,
    // trigger-count clear, trigger-error clear, busy clear and soft reset
    int                 high_cnt [PULSE_SLOTS] = '{default: 0};

    sru_ctrl_top dut0 (.*);

    always #(CLK_PERIOD / 2) dcsclk = ~dcsclk;

    // ------------------------------
    // helpers
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // host byte address is the word index times four
    function automatic logic [AXIL_AW-1:0] byte_addr(input reg_idx_t idx);
        return {idx, 2'b00};
    endfunction

    function automatic logic pulse_now(input int slot);
        case (slot)
            0:       return walign_o;
            1:       return ddlinit_o;
            2:       return strig_o;
            3:       return fast_cmd_o;
            4:       return errtest_o;
            5:       return trigcnt_clr_o;
            6:       return trigerr_clr_o;
            7:       return busy_clr_o;
            default: return soft_rst_o;
        endcase
    endfunction

    // true when some channel carries a flag and its mask bit is clear
    function automatic logic any_unmasked(input mask40_t flags, input mask40_t mask);
        logic hit;
        hit = 1'b0;
        for (int ch = 0; ch < 40; ch++) begin
            if (flags[ch] && !mask[ch]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // each counter adds one for every clock edge that sees its pulse high
    always @(posedge dcsclk) begin
        for (int i = 0; i < PULSE_SLOTS; i++) begin
            if (pulse_now(i)) begin
                high_cnt[i] <= high_cnt[i] + 1;
            end
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_mask(input string name, input mask40_t exp, input mask40_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // ------------------------------
    // host bus transactions, outputs are sampled at the edge as the DUT sees them
    task automatic axil_write(input reg_idx_t idx, input word_t data);
        @(posedge dcsclk);
        s_awaddr_i  <= byte_addr(idx);
        s_wdata_i   <= data;
        s_awvalid_i <= 1'b1;
        s_wvalid_i  <= 1'b1;
        do @(posedge dcsclk); while (!(s_awready_o && s_wready_o));
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        do @(posedge dcsclk); while (!s_bvalid_o);
        check_resp("write response", RESP_OKAY, s_bresp_o);
    endtask

    task automatic axil_read(input reg_idx_t idx, output word_t data, output resp_t resp);
        @(posedge dcsclk);
        s_araddr_i  <= byte_addr(idx);
        s_arvalid_i <= 1'b1;
        do @(posedge dcsclk); while (!s_arready_o);
        s_arvalid_i <= 1'b0;
        do @(posedge dcsclk); while (!s_rvalid_o);
        data = s_rdata_o;
        resp = s_rresp_o;
    endtask

    task automatic read_expect(input string name, input reg_idx_t idx, input word_t exp);
        word_t data;
        resp_t resp;
        axil_read(idx, data, resp);
        check_word(name, exp, data);
        check_resp({name, " response"}, RESP_OKAY, resp);
    endtask

    // ------------------------------
    // directed tests
    task automatic check_defaults();
        read_expect("default srucfg", ADDR_SRUCFG, 32'h0000_0007);
        read_expect("default mask lo", ADDR_MASK_LO, 32'h000F_FFFF);
        read_expect("default mask hi", ADDR_MASK_HI, 32'h000F_FFFF);
        read_expect("default trigl1tw", ADDR_TRIGL1TW, {16'd300, 16'd120});
        read_expect("default trigl2tw", ADDR_TRIGL2TW, {16'd20000, 16'd200});
        read_expect("default ptrigcfg", ADDR_PTRIGCFG, 32'h0000_4E20);
        read_expect("firmware version", ADDR_FW_VER, FW_VERSION);
        read_expect("serial number", ADDR_SRU_SN, SN_VALUE);
        check_mask("default rdo_mask_o", 40'hFF_FFFF_FFFF, rdo_mask_o);
        check_word("default srucfg_o", 32'h0000_0007, srucfg_o);
        check_word("default trigl1tw_o", {16'd300, 16'd120}, trigl1tw_o);
        check_word("default trigl2tw_o", {16'd20000, 16'd200}, trigl2tw_o);
        check_word("default ptrigcfg_o", 32'h0000_4E20, word_t'(ptrigcfg_o));
    endtask

    task automatic test_cfg_rw();
        word_t cfg, lo, hi, l1, l2, pt, data;
        resp_t resp;
        cfg = lcg_next();
        lo  = lcg_next();
        hi  = lcg_next();
        l1  = lcg_next();
        l2  = lcg_next();
        pt  = lcg_next();
        axil_write(ADDR_SRUCFG, cfg);
        axil_write(ADDR_MASK_LO, lo);
        axil_write(ADDR_MASK_HI, hi);
        axil_write(ADDR_TRIGL1TW, l1);
        axil_write(ADDR_TRIGL2TW, l2);
        axil_write(ADDR_PTRIGCFG, pt);
        read_expect("srucfg readback", ADDR_SRUCFG, cfg);
        // the mask halves are 20 bits wide and the pulser word 17 bits
        read_expect("mask lo readback", ADDR_MASK_LO, lo & 32'h000F_FFFF);
        read_expect("mask hi readback", ADDR_MASK_HI, hi & 32'h000F_FFFF);
        read_expect("trigl1tw readback", ADDR_TRIGL1TW, l1);
        read_expect("trigl2tw readback", ADDR_TRIGL2TW, l2);
        read_expect("ptrigcfg readback", ADDR_PTRIGCFG, pt & 32'h0001_FFFF);
        check_mask("rdo_mask_o", {hi[19:0], lo[19:0]}, rdo_mask_o);
        check_word("srucfg_o", cfg, srucfg_o);
        check_word("trigl1tw_o", l1, trigl1tw_o);
        check_word("trigl2tw_o", l2, trigl2tw_o);
        check_word("ptrigcfg_o", pt & 32'h0001_FFFF, word_t'(ptrigcfg_o));
        axil_read(16'h0077, data, resp);
        check_word("unmapped read data", 32'h0, data);
        check_resp("unmapped read response", RESP_SLVERR, resp);
    endtask

    task automatic measure_pulse(input string name, input int slot, input reg_idx_t idx,
                                 input word_t data, input word_t len);
        int start;
        start = high_cnt[slot];
        axil_write(idx, data);
        do @(posedge dcsclk); while (pulse_now(slot));
        check_word(name, len, word_t'(high_cnt[slot] - start));
    endtask

    task automatic test_pulses();
        word_t code;
        code = lcg_next();
        measure_pulse("walign length", 0, ADDR_WALIGN, 32'h0, 32'd32);
        measure_pulse("ddlinit length", 1, ADDR_DDLINIT, 32'h0, 32'd16);
        measure_pulse("strig length", 2, ADDR_STRIG, 32'h0, 32'd1);
        measure_pulse("fast command length", 3, ADDR_FAST_CMD, code, 32'd16);
        check_word("fast command code", {24'h0, code[7:0]}, {24'h0, fast_cmd_code_o});
        measure_pulse("errtest length", 4, ADDR_ERRTEST, 32'h0, 32'd32);
        measure_pulse("trigcnt_clr length", 5, ADDR_TRIGCNT_CLR, 32'h0, 32'd1);
        measure_pulse("trigerr_clr length", 6, ADDR_TRIGERR_CLR, 32'h0, 32'd1);
    endtask

    task automatic test_soft_reset();
        int fast_start;
        fast_start = high_cnt[3];
        axil_write(ADDR_SRUCFG, 32'hA5A5_0000);
        axil_write(ADDR_MASK_LO, 32'h0);
        measure_pulse("soft reset length", 8, ADDR_RESET, 32'h0, 32'd1);
        check_bit("reset fast command", 1'b1, fast_cmd_o);
        check_defaults();
        check_word("reset fast code", 32'h0000_00E8, {24'h0, fast_cmd_code_o});
        do @(posedge dcsclk); while (fast_cmd_o);
        check_word("reset fast command length", 32'd16, word_t'(high_cnt[3] - fast_start));
    endtask

    // a set mask bit hides the channel from both summary flags
    task automatic flag_case(input mask40_t mask, input mask40_t err, input mask40_t sync);
        @(posedge dcsclk);
        dtc_err_flag_i <= err;
        dtc_sync_err_i <= sync;
        axil_write(ADDR_MASK_LO, {12'h000, mask[19:0]});
        axil_write(ADDR_MASK_HI, {12'h000, mask[39:20]});
        read_expect("error flags lo", ADDR_ERR_LO, {12'h000, err[19:0]});
        read_expect("error flags hi", ADDR_ERR_HI, {12'h000, err[39:20]});
        check_bit("fee_err_or_o", any_unmasked(sync, mask), fee_err_or_o);
        check_bit("dtc_link_or_o", any_unmasked(err, mask), dtc_link_or_o);
    endtask

    task automatic test_err_flags();
        word_t w0, w1, w2, w3, w4, w5;
        w0 = lcg_next();
        w1 = lcg_next();
        w2 = lcg_next();
        w3 = lcg_next();
        w4 = lcg_next();
        w5 = lcg_next();
        flag_case({w0[7:0], w1}, {w2[7:0], w3}, {w4[7:0], w5});
        flag_case(40'hFF_FFFF_FFFF, {w2[7:0], w3}, {w4[7:0], w5});
        // channel 37 open with only a sync error, then channel 5 with only a link error
        flag_case(~(40'h1 << 37), 40'h0, 40'h1 << 37);
        flag_case(~(40'h1 << 5), 40'h1 << 5, 40'h1 << 6);
    endtask

    task automatic test_busy_cnt();
        word_t n, st;
        n  = 32'd20 + (lcg_next() & 32'h1F);
        // status word for the readback, bit 0 clear so the counter stays put
        st = lcg_next() & 32'hFFFF_FFFE;
        measure_pulse("busy_clr length", 7, ADDR_BUSY_CLR, 32'h0, 32'd1);
        @(posedge dcsclk);
        sru_status_i <= 32'h1;
        repeat (n) @(posedge dcsclk);
        sru_status_i <= st;
        read_expect("busy count", ADDR_BUSY_CNT, n);
        read_expect("unit status", ADDR_SRU_STATUS, st);
        axil_write(ADDR_BUSY_CLR, 32'h0);
        read_expect("busy count cleared", ADDR_BUSY_CNT, 32'h0);
    endtask

    task automatic test_bresp_stall();
        word_t first;
        first = lcg_next();
        @(posedge dcsclk);
        s_bready_i  <= 1'b0;
        s_awaddr_i  <= byte_addr(ADDR_SRUCFG);
        s_wdata_i   <= first;
        s_awvalid_i <= 1'b1;
        s_wvalid_i  <= 1'b1;
        do @(posedge dcsclk); while (!(s_awready_o && s_wready_o));
        // the channels stay valid, so a second write is on offer during the stall
        s_wdata_i <= ~first;
        do @(posedge dcsclk); while (!s_bvalid_o);
        repeat (8) begin
            @(posedge dcsclk);
            check_bit("bvalid held", 1'b1, s_bvalid_o);
            check_bit("awready during stall", 1'b0, s_awready_o);
            check_bit("wready during stall", 1'b0, s_wready_o);
        end
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        s_bready_i  <= 1'b1;
        do @(posedge dcsclk); while (s_bvalid_o);
        read_expect("stalled write kept", ADDR_SRUCFG, first);
    endtask

    // ------------------------------
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        reset          = 1'b1;
        s_awaddr_i     = '0;
        s_araddr_i     = '0;
        s_awvalid_i    = 1'b0;
        s_wvalid_i     = 1'b0;
        s_arvalid_i    = 1'b0;
        s_bready_i     = 1'b1;
        s_rready_i     = 1'b1;
        s_wdata_i      = '0;
        sru_sn_i       = SN_VALUE;
        sru_status_i   = '0;
        dtc_err_flag_i = '0;
        dtc_sync_err_i = '0;
        repeat (4) @(posedge dcsclk);
        reset <= 1'b0;
        // release fires a soft reset and the reset fast command
        do @(posedge dcsclk); while (!fast_cmd_o);
        do @(posedge dcsclk); while (fast_cmd_o);
        check_defaults();
        test_cfg_rw();
        test_pulses();
        test_soft_reset();
        test_err_flags();
        test_busy_cnt();
        test_bresp_stall();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: common/axil_pkg.sv
package axil_pkg;

    // host side byte address width, 18 bits cover the 16-bit word index
    localparam int AXIL_AW = 18;

    typedef logic [1:0] resp_t;

    // only OKAY and SLVERR are ever returned
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // registers are 32-bit words, so the low two address bits drop out
    function automatic logic [AXIL_AW-3:0] word_idx(input logic [AXIL_AW-1:0] byte_addr);
        return byte_addr[AXIL_AW-1:2];
    endfunction

endpackage

// File: common/reg_bus_if.sv
interface reg_bus_if
    import sru_map_pkg::*;
();

    // one-cycle strobes, never high together
    logic     wr_en;
    logic     rd_en;
    reg_idx_t addr;
    word_t    wdata;
    // read data and hit come back registered, one cycle after rd_en
    word_t    rdata;
    logic     rd_hit;

    // the host bridge owns the strobes, address and write data
    modport master (output wr_en, rd_en, addr, wdata, input rdata, rd_hit);

    // the register bank is the only peer that answers reads
    modport peer_bank (input wr_en, rd_en, addr, wdata, output rdata, rd_hit);

    // the command unit only listens to writes
    modport peer_cmd (input wr_en, addr, wdata);

endinterface

// File: common/sru_map_pkg.sv
package sru_map_pkg;

    // register word, per-channel vector and register index
    typedef logic [31:0] word_t;
    typedef logic [39:0] mask40_t;
    typedef logic [15:0] reg_idx_t;

    // ------------------------------
    // read-only status words
    localparam reg_idx_t ADDR_SRU_SN      = 16'h0001;
    localparam reg_idx_t ADDR_FW_VER      = 16'h0003;
    localparam reg_idx_t ADDR_SRU_STATUS  = 16'h0004;
    localparam reg_idx_t ADDR_ERR_LO      = 16'h0005;
    localparam reg_idx_t ADDR_ERR_HI      = 16'h0006;
    localparam reg_idx_t ADDR_BUSY_CNT    = 16'h0079;

    // command strobes, only the write matters and the data is ignored except for fast command
    localparam reg_idx_t ADDR_RESET       = 16'h0010;
    localparam reg_idx_t ADDR_WALIGN      = 16'h0012;
    localparam reg_idx_t ADDR_BUSY_CLR    = 16'h0013;
    localparam reg_idx_t ADDR_DDLINIT     = 16'h0014;
    localparam reg_idx_t ADDR_FAST_CMD    = 16'h0041;
    localparam reg_idx_t ADDR_STRIG       = 16'h0042;
    localparam reg_idx_t ADDR_TRIGCNT_CLR = 16'h0043;
    localparam reg_idx_t ADDR_TRIGERR_CLR = 16'h0044;
    localparam reg_idx_t ADDR_ERRTEST     = 16'h0045;

    // read-write configuration words
    localparam reg_idx_t ADDR_SRUCFG      = 16'h0020;
    localparam reg_idx_t ADDR_MASK_LO     = 16'h0023;
    localparam reg_idx_t ADDR_MASK_HI     = 16'h0024;
    localparam reg_idx_t ADDR_TRIGL1TW    = 16'h0029;
    localparam reg_idx_t ADDR_TRIGL2TW    = 16'h002A;
    localparam reg_idx_t ADDR_PTRIGCFG    = 16'h0050;

    // ------------------------------
    localparam word_t FW_VERSION = 32'h1212_0601;
    localparam int    HALF_W     = 20;
    localparam int    PTRIG_W    = 17;

    // defaults loaded by every soft reset
    localparam word_t               DEF_SRUCFG   = 32'h0000_0007;
    localparam mask40_t             DEF_RDO_MASK = '1;
    localparam word_t               DEF_TRIGL1TW = {16'd300, 16'd120};
    localparam word_t               DEF_TRIGL2TW = {16'd20000, 16'd200};
    // 0x4E20 pulser period is 500 us at the 40 MHz slow-control clock
    localparam logic [PTRIG_W-1:0]  DEF_PTRIGCFG = 17'h04E20;

    // ------------------------------
    // pulse stretchers shift out of the msb, so the load pattern sets the length
    localparam int LONG_PULSE  = 32;
    localparam int SHORT_PULSE = 16;
    typedef logic [LONG_PULSE-1:0] stretch_t;
    localparam stretch_t LOAD_LONG  = '1;
    localparam stretch_t LOAD_SHORT = {{SHORT_PULSE{1'b1}}, {(LONG_PULSE-SHORT_PULSE){1'b0}}};

    // fast command code sent along with every soft reset
    localparam logic [7:0] RESET_FAST_CODE = 8'hE8;

endpackage

// File: host_if/sru_axil_slave.sv
module sru_axil_slave
    import sru_map_pkg::*, axil_pkg::*;
(
    input  logic               dcsclk,
    input  logic               reset,
    // write address and data channels
    input  logic [AXIL_AW-1:0] s_awaddr_i,
    input  logic               s_awvalid_i,
    output logic               s_awready_o,
    input  word_t              s_wdata_i,
    input  logic               s_wvalid_i,
    output logic               s_wready_o,
    // write response channel
    output resp_t              s_bresp_o,
    output logic               s_bvalid_o,
    input  logic               s_bready_i,
    // read channels
    input  logic [AXIL_AW-1:0] s_araddr_i,
    input  logic               s_arvalid_i,
    output logic               s_arready_o,
    output word_t              s_rdata_o,
    output resp_t              s_rresp_o,
    output logic               s_rvalid_o,
    input  logic               s_rready_i,
    reg_bus_if.master          bus
);

    // one transaction at a time, every phase takes its own state
    typedef enum logic [2:0] {
        S_IDLE, S_WACC, S_WSTB, S_BRESP, S_RACC, S_RSTB, S_RDAT, S_RRESP
    } state_t;

    state_t state_q;
    word_t  rdata_q;
    resp_t  rresp_q;

    // ------------------------------
    // control FSM
    always_ff @(posedge dcsclk) begin
        if (reset) begin
            state_q     <= S_IDLE;
            s_awready_o <= 1'b0;
            s_wready_o  <= 1'b0;
            s_arready_o <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_rvalid_o  <= 1'b0;
            bus.wr_en   <= 1'b0;
            bus.rd_en   <= 1'b0;
        end else begin
            // bus strobes drop back after one cycle
            bus.wr_en <= 1'b0;
            bus.rd_en <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    // a write needs both channels and beats a read in the same cycle
                    if (s_awvalid_i && s_wvalid_i) begin
                        s_awready_o <= 1'b1;
                        s_wready_o  <= 1'b1;
                        state_q     <= S_WACC;
                    end else if (s_arvalid_i) begin
                        s_arready_o <= 1'b1;
                        state_q     <= S_RACC;
                    end
                end
                // handshake completes in this cycle, the bus write follows
                S_WACC: begin
                    s_awready_o <= 1'b0;
                    s_wready_o  <= 1'b0;
                    bus.wr_en   <= 1'b1;
                    state_q     <= S_WSTB;
                end
                S_WSTB: begin
                    s_bvalid_o <= 1'b1;
                    state_q    <= S_BRESP;
                end
                S_BRESP: begin
                    if (s_bready_i) begin
                        s_bvalid_o <= 1'b0;
                        state_q    <= S_IDLE;
                    end
                end
                S_RACC: begin
                    s_arready_o <= 1'b0;
                    bus.rd_en   <= 1'b1;
                    state_q     <= S_RSTB;
                end
                // the bank registers its answer at the end of this cycle
                S_RSTB: begin
                    state_q <= S_RDAT;
                end
                S_RDAT: begin
                    s_rvalid_o <= 1'b1;
                    state_q    <= S_RRESP;
                end
                S_RRESP: begin
                    if (s_rready_i) begin
                        s_rvalid_o <= 1'b0;
                        state_q    <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ------------------------------
    // address, write data and read reply are captured while their state is active
    always_ff @(posedge dcsclk) begin
        if (state_q == S_WACC) begin
            bus.addr  <= word_idx(s_awaddr_i);
            bus.wdata <= s_wdata_i;
        end else if (state_q == S_RACC) begin
            bus.addr <= word_idx(s_araddr_i);
        end
        if (state_q == S_RDAT) begin
            rdata_q <= bus.rdata;
            rresp_q <= bus.rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // unmapped writes are dropped silently so every write answers OKAY
    assign s_bresp_o = RESP_OKAY;
    assign s_rdata_o = rdata_q;
    assign s_rresp_o = rresp_q;

    // responses stay up until the host takes them
    a_bvalid_hold: assert property (@(posedge dcsclk) disable iff (reset)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o);
    a_rvalid_hold: assert property (@(posedge dcsclk) disable iff (reset)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o);
    a_one_strobe: assert property (@(posedge dcsclk) disable iff (reset)
        !(bus.wr_en && bus.rd_en));

endmodule

// File: logic/sru_cmd_pulse.sv
module sru_cmd_pulse
    import sru_map_pkg::*;
(
    input  logic         dcsclk,
    input  logic         reset,
    reg_bus_if.peer_cmd  bus,
    // one-cycle strobes
    output logic         soft_rst_o,
    output logic         busy_clr_o,
    output logic         strig_o,
    output logic         trigcnt_clr_o,
    output logic         trigerr_clr_o,
    // stretched pulses
    output logic         walign_o,
    output logic         errtest_o,
    output logic         ddlinit_o,
    output logic         fast_cmd_o,
    output logic [7:0]   fast_cmd_code_o
);

    // stretcher slots, 0 walign and 1 errtest are long, 2 ddlinit and 3 fast command are short
    logic [3:0] str_hit;
    stretch_t   str_q [4];
    // high during reset so the first cycle after release fires the soft reset
    logic       rst_rel_q;

    always_comb begin
        str_hit[0] = bus.wr_en && (bus.addr == ADDR_WALIGN);
        str_hit[1] = bus.wr_en && (bus.addr == ADDR_ERRTEST);
        str_hit[2] = bus.wr_en && (bus.addr == ADDR_DDLINIT);
        str_hit[3] = bus.wr_en && (bus.addr == ADDR_FAST_CMD);
    end

    // ------------------------------
    always_ff @(posedge dcsclk) begin
        if (reset) begin
            rst_rel_q     <= 1'b1;
            soft_rst_o    <= 1'b0;
            busy_clr_o    <= 1'b0;
            strig_o       <= 1'b0;
            trigcnt_clr_o <= 1'b0;
            trigerr_clr_o <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                str_q[i] <= '0;
            end
        end else begin
            rst_rel_q  <= 1'b0;
            soft_rst_o <= rst_rel_q || (bus.wr_en && bus.addr == ADDR_RESET);
            if (soft_rst_o) begin
                // soft reset quiets everything except the reset fast command
                busy_clr_o    <= 1'b0;
                strig_o       <= 1'b0;
                trigcnt_clr_o <= 1'b0;
                trigerr_clr_o <= 1'b0;
                for (int i = 0; i < 3; i++) begin
                    str_q[i] <= '0;
                end
                str_q[3] <= LOAD_SHORT;
            end else begin
                busy_clr_o    <= bus.wr_en && (bus.addr == ADDR_BUSY_CLR);
                strig_o       <= bus.wr_en && (bus.addr == ADDR_STRIG);
                trigcnt_clr_o <= bus.wr_en && (bus.addr == ADDR_TRIGCNT_CLR);
                trigerr_clr_o <= bus.wr_en && (bus.addr == ADDR_TRIGERR_CLR);
                // a repeated command reloads its stretcher and restarts the pulse
                for (int i = 0; i < 4; i++) begin
                    if (str_hit[i]) begin
                        str_q[i] <= (i < 2) ? LOAD_LONG : LOAD_SHORT;
                    end else begin
                        str_q[i] <= str_q[i] << 1;
                    end
                end
            end
        end
    end

    // the code is payload and only follows a fast command or a soft reset
    always_ff @(posedge dcsclk) begin
        if (soft_rst_o) begin
            fast_cmd_code_o <= RESET_FAST_CODE;
        end else if (str_hit[3]) begin
            fast_cmd_code_o <= bus.wdata[7:0];
        end
    end

    assign walign_o   = str_q[0][LONG_PULSE-1];
    assign errtest_o  = str_q[1][LONG_PULSE-1];
    assign ddlinit_o  = str_q[2][LONG_PULSE-1];
    assign fast_cmd_o = str_q[3][LONG_PULSE-1];

    // the bus spaces its writes, so a soft reset can never run two cycles
    a_soft_rst_pulse: assert property (@(posedge dcsclk) disable iff (reset)
        soft_rst_o |=> !soft_rst_o);

endmodule

// File: logic/sru_ctrl_top.sv
module sru_ctrl_top
    import sru_map_pkg::*, axil_pkg::*;
(
    input  logic               dcsclk,
    input  logic               reset,
    // AXI4-Lite host port
    input  logic [AXIL_AW-1:0] s_awaddr_i,
    input  logic               s_awvalid_i,
    output logic               s_awready_o,
    input  word_t              s_wdata_i,
    input  logic               s_wvalid_i,
    output logic               s_wready_o,
    output resp_t              s_bresp_o,
    output logic               s_bvalid_o,
    input  logic               s_bready_i,
    input  logic [AXIL_AW-1:0] s_araddr_i,
    input  logic               s_arvalid_i,
    output logic               s_arready_o,
    output word_t              s_rdata_o,
    output resp_t              s_rresp_o,
    output logic               s_rvalid_o,
    input  logic               s_rready_i,
    // status from the rest of the unit
    input  word_t              sru_sn_i,
    input  word_t              sru_status_i,
    input  mask40_t            dtc_err_flag_i,
    input  mask40_t            dtc_sync_err_i,
    // configuration
    output word_t              srucfg_o,
    output mask40_t            rdo_mask_o,
    output word_t              trigl1tw_o,
    output word_t              trigl2tw_o,
    output logic [PTRIG_W-1:0] ptrigcfg_o,
    output logic               fee_err_or_o,
    output logic               dtc_link_or_o,
    // commands
    output logic               soft_rst_o,
    output logic               busy_clr_o,
    output logic               strig_o,
    output logic               trigcnt_clr_o,
    output logic               trigerr_clr_o,
    output logic               walign_o,
    output logic               errtest_o,
    output logic               ddlinit_o,
    output logic               fast_cmd_o,
    output logic [7:0]         fast_cmd_code_o
);

    // shared register bus, one master and two listening peers
    reg_bus_if bus ();

    // port names match the top level, so the wildcard picks up the AXI side
    sru_axil_slave u_axil_slave (.*, .bus(bus));

    sru_cmd_pulse u_cmd_pulse (.*, .bus(bus));

    // the bank only sees the soft reset, so its defaults load right after reset release
    sru_reg_bank u_reg_bank (
        .*,
        .soft_rst_i (soft_rst_o),
        .busy_clr_i (busy_clr_o),
        .bus        (bus)
    );

endmodule

// File: logic/sru_reg_bank.sv
module sru_reg_bank
    import sru_map_pkg::*;
(
    input  logic               dcsclk,
    input  logic               soft_rst_i,
    input  logic               busy_clr_i,
    reg_bus_if.peer_bank       bus,
    // status inputs
    input  word_t              sru_sn_i,
    input  word_t              sru_status_i,
    input  mask40_t            dtc_err_flag_i,
    input  mask40_t            dtc_sync_err_i,
    // configuration outputs
    output word_t              srucfg_o,
    output mask40_t            rdo_mask_o,
    output word_t              trigl1tw_o,
    output word_t              trigl2tw_o,
    output logic [PTRIG_W-1:0] ptrigcfg_o,
    // masked error summaries
    output logic               fee_err_or_o,
    output logic               dtc_link_or_o
);

    word_t busy_cnt_q;

    // ------------------------------
    // configuration registers, soft reset reloads every default
    always_ff @(posedge dcsclk) begin
        if (soft_rst_i) begin
            srucfg_o   <= DEF_SRUCFG;
            rdo_mask_o <= DEF_RDO_MASK;
            trigl1tw_o <= DEF_TRIGL1TW;
            trigl2tw_o <= DEF_TRIGL2TW;
            ptrigcfg_o <= DEF_PTRIGCFG;
        end else if (bus.wr_en) begin
            case (bus.addr)
                ADDR_SRUCFG:   srucfg_o <= bus.wdata;
                // each mask half comes from the low 20 data bits
                ADDR_MASK_LO:  rdo_mask_o[HALF_W-1:0] <= bus.wdata[HALF_W-1:0];
                ADDR_MASK_HI:  rdo_mask_o[2*HALF_W-1:HALF_W] <= bus.wdata[HALF_W-1:0];
                ADDR_TRIGL1TW: trigl1tw_o <= bus.wdata;
                ADDR_TRIGL2TW: trigl2tw_o <= bus.wdata;
                ADDR_PTRIGCFG: ptrigcfg_o <= bus.wdata[PTRIG_W-1:0];
                default: ;
            endcase
        end
    end

    // busy cycles are counted while bit 0 of the unit status is set
    always_ff @(posedge dcsclk) begin
        if (soft_rst_i || busy_clr_i) begin
            busy_cnt_q <= '0;
        end else if (sru_status_i[0]) begin
            busy_cnt_q <= busy_cnt_q + 1'b1;
        end
    end

    // ------------------------------
    // read mux, registered on rd_en and held until the next read
    always_ff @(posedge dcsclk) begin
        if (bus.rd_en) begin
            bus.rd_hit <= 1'b1;
            case (bus.addr)
                ADDR_SRU_SN:     bus.rdata <= sru_sn_i;
                ADDR_FW_VER:     bus.rdata <= FW_VERSION;
                ADDR_SRU_STATUS: bus.rdata <= sru_status_i;
                ADDR_ERR_LO:     bus.rdata <= word_t'(dtc_err_flag_i[HALF_W-1:0]);
                ADDR_ERR_HI:     bus.rdata <= word_t'(dtc_err_flag_i[2*HALF_W-1:HALF_W]);
                ADDR_BUSY_CNT:   bus.rdata <= busy_cnt_q;
                ADDR_SRUCFG:     bus.rdata <= srucfg_o;
                ADDR_MASK_LO:    bus.rdata <= word_t'(rdo_mask_o[HALF_W-1:0]);
                ADDR_MASK_HI:    bus.rdata <= word_t'(rdo_mask_o[2*HALF_W-1:HALF_W]);
                ADDR_TRIGL1TW:   bus.rdata <= trigl1tw_o;
                ADDR_TRIGL2TW:   bus.rdata <= trigl2tw_o;
                ADDR_PTRIGCFG:   bus.rdata <= word_t'(ptrigcfg_o);
                // command and unknown addresses read as zero with no hit
                default: begin
                    bus.rdata  <= '0;
                    bus.rd_hit <= 1'b0;
                end
            endcase
        end
    end

    // a set mask bit excludes the channel from both summaries
    assign fee_err_or_o  = |(dtc_sync_err_i & ~rdo_mask_o);
    assign dtc_link_or_o = |(dtc_err_flag_i & ~rdo_mask_o);

endmodule

// File: sim.f
common/sru_map_pkg.sv
common/axil_pkg.sv
common/reg_bus_if.sv
host_if/sru_axil_slave.sv
logic/sru_reg_bank.sv
logic/sru_cmd_pulse.sv
logic/sru_ctrl_top.sv
bench/sru_ctrl_tb.sv
